// ==== Bender.yml ====
package:
  name: scene_controller

sources:
  - files:
      - hdl/scenePkg.sv
      - hdl/advanceInputs.sv
      - hdl/sceneSequencer.sv
      - hdl/framePainter.sv
      - hdl/sceneController.sv
  - target: test
    files:
      - dv/sceneController_assertions.sv
      - dv/sceneControllerTb.sv

// ==== dv/sceneControllerTb.sv ====
module sceneControllerTb;

	// Small screen and fast pacing so a run stays short
	localparam int screenWidth = 6;
	localparam int screenHeight = 4;
	localparam int tickCycles = 30;
	localparam int pixelsPerFrame = screenWidth * screenHeight;
	localparam int clkPeriod = 10;
	localparam int resetCycles = 8;
	// Button hold length in clocks
	localparam int pressCycles = 4;

	// One line of the stimulus file
	typedef struct packed {
		logic [2:0] scene;
		logic press;
		logic [7:0] pressAt;
		logic [7:0] readyPct;
	} frameStim_t;

	logic clk;
	logic rst;
	logic userCont;
	logic pixelReady;
	scenePkg::pixel_t pixel;
	logic pixelValid;

	frameStim_t stimQ[$];
	bit stimLoaded;
	int numFrames;
	int frameIdx;
	int pixIdx;
	int modelScene;
	int pressLeft;
	longint limitCycles;
	frameStim_t cur;

	sceneController #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.tickCycles(tickCycles)
	) UUT (
		.clk(clk),
		.rst(rst),
		.userCont(userCont),
		.pixelReady(pixelReady),
		.pixel(pixel),
		.pixelValid(pixelValid)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	// Compare and stop at the first mismatch
	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			$display("** Error at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// Bound assertion failures end the run like a value mismatch
	always @(UUT.chk.failCount)
		checkValue("assertion failures", 0, UUT.chk.failCount);

	// Scene order from the scene rules, press only counts in titles
	function automatic int successorScene(input int scene, input bit pressed);
		int next;
		if (scene <= 2 && pressed) begin
			next = 3;
		end else begin
			case (scene)
				0: next = 1;
				1: next = 2;
				2: next = 0;
				3: next = 4;
				default: next = 3;
			endcase
		end
		return next;
	endfunction

	// Read frame lines, skipping comments and blanks
	task automatic loadStimulus();
		int fd;
		int code;
		int sc;
		int pr;
		int at;
		int pct;
		string line;
		frameStim_t entry;
		fd = $fopen("dv/sceneStim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file dv/sceneStim.txt");
			$display("TESTS FAILED");
			$fatal(1, "missing stimulus file");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %d %d", sc, pr, at, pct) == 4) begin
						entry.scene = 3'(sc);
						entry.press = (pr != 0);
						entry.pressAt = 8'(at);
						entry.readyPct = 8'(pct);
						stimQ.push_back(entry);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Expected record from the raster rule
	task automatic checkRecord(input int idx, input int scene);
		checkValue("pixel.x", idx % screenWidth, int'(pixel.x));
		checkValue("pixel.y", idx / screenWidth, int'(pixel.y));
		checkValue("pixel.addr", idx, int'(pixel.addr));
		checkValue("pixel.scene", scene, int'(pixel.scene));
		checkValue("pixel.last", (idx == pixelsPerFrame - 1) ? 1 : 0, int'(pixel.last));
	endtask

	// Called just after a rising edge
	task automatic driveInputs();
		int pct;
		pct = (frameIdx < numFrames) ? int'(stimQ[frameIdx].readyPct) : 100;
		pixelReady = (($urandom % 100) < pct);
		if (pressLeft > 0) begin
			userCont = 1'b1;
			pressLeft--;
		end else begin
			userCont = 1'b0;
		end
	endtask

	// Limit grows with the number of frames in the file
	initial begin : watchdog
		wait (stimLoaded);
		limitCycles = longint'(numFrames) * pixelsPerFrame * 20
			+ longint'(tickCycles) * numFrames + resetCycles;
		#(limitCycles * clkPeriod);
		$display("Run timed out before every frame in the stimulus file was checked");
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : mainSeq
		rst = 1'b1;
		userCont = 1'b0;
		pixelReady = 1'b0;
		frameIdx = 0;
		pixIdx = 0;
		modelScene = 0;
		pressLeft = 0;
		numFrames = 0;
		void'($urandom(52603));

		loadStimulus();
		numFrames = stimQ.size();
		if (numFrames == 0) begin
			$display("The stimulus file holds no frame lines");
			$display("TESTS FAILED");
			$fatal(1, "empty stimulus");
		end
		stimLoaded = 1'b1;

		// Stream must stay quiet through reset
		repeat (resetCycles) begin
			@(posedge clk);
			#1;
			checkValue("pixelValid", 0, int'(pixelValid));
		end
		rst = 1'b0;
		driveInputs();

		while (frameIdx < numFrames) begin
			@(negedge clk);
			cur = stimQ[frameIdx];
			// Valid and ready are both settled at the falling edge
			if (pixelValid && pixelReady) begin
				if (pixIdx == 0)
					checkValue("stim scene", modelScene, int'(cur.scene));
				checkRecord(pixIdx, modelScene);
				if (cur.press && pixIdx == int'(cur.pressAt))
					pressLeft = pressCycles;
				pixIdx++;
				// Frame complete, step the model
				if (pixIdx == pixelsPerFrame) begin
					modelScene = successorScene(modelScene, cur.press);
					pixIdx = 0;
					frameIdx++;
				end
			end
			@(posedge clk);
			#1;
			driveInputs();
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== dv/sceneController_assertions.sv ====
module sceneControllerAssertions #(
	parameter int frameSize = scenePkg::maxWidth * scenePkg::maxHeight
) (
	input logic clk,
	input logic rst,
	input scenePkg::pixel_t pixel,
	input logic pixelValid,
	input logic pixelReady,
	input scenePkg::paintReq_t paintReq,
	input logic paintValid,
	input logic paintReady,
	input logic frameDone
);

	// Failed assertion count
	int failCount = 0;

	// Stream idle right after a reset edge
	resetQuiet: assert property (@(posedge clk) rst |=> !pixelValid)
		else begin
			$error("pixelValid high after a reset cycle");
			failCount++;
		end

	// Stalled record holds
	pixelHold: assert property (@(posedge clk) disable iff (rst)
		pixelValid && !pixelReady |=> pixelValid && $stable(pixel))
		else begin
			$error("pixel record changed while stalled");
			failCount++;
		end

	// Paint request waits for the painter
	paintHold: assert property (@(posedge clk) disable iff (rst)
		paintValid && !paintReady |=> paintValid && $stable(paintReq))
		else begin
			$error("paint request dropped before acceptance");
			failCount++;
		end

	// Frame end only with the final address moving as the last record
	doneOnLast: assert property (@(posedge clk) disable iff (rst)
		frameDone == (pixelValid && pixelReady && pixel.last &&
			pixel.addr == scenePkg::addrBits'(frameSize - 1)))
		else begin
			$error("frameDone out of step with the last transfer");
			failCount++;
		end

endmodule

bind sceneController sceneControllerAssertions #(
	.frameSize(screenWidth * screenHeight)
) chk (
	.clk(clk),
	.rst(rst),
	.pixel(pixel),
	.pixelValid(pixelValid),
	.pixelReady(pixelReady),
	.paintReq(paintReq),
	.paintValid(paintValid),
	.paintReady(paintReady),
	.frameDone(frameDone)
);

// ==== dv/sceneStim.txt ====
# One line per frame in transfer order
# Columns: expected scene, press flag, press pixel index, pixelReady percent
0 0 0 100
1 0 0 70
2 0 0 50
0 0 0 100
1 0 0 80
2 1 3 60
3 0 0 100
4 1 5 70
3 0 0 40
4 1 0 90
3 0 0 100
4 0 0 50
3 1 8 65
4 0 0 100
3 0 0 75
4 1 10 35
3 0 0 100
4 0 0 85
3 0 0 55
4 0 0 100

// ==== hdl/advanceInputs.sv ====
module advanceInputs #(
	parameter int tickCycles = 12_500_000
) (
	input logic clk,
	input logic rst,
	input logic userCont,
	input logic restart,
	output logic contReq,
	output logic tickReq
);

	// Pacing counter wide enough for tickCycles
	localparam int cntBits = $clog2(tickCycles + 1);

	// Two flop synchronizer on the raw button
	logic [1:0] contSync;
	// Previous synchronized level for edge detect
	logic contPrev;
	logic contRise;
	logic [cntBits-1:0] tickCount;

	assign contRise = contSync[1] & ~contPrev;

	// Button sync and sticky continue request
	always_ff @(posedge clk) begin
		if (rst) begin
			contSync <= 2'b00;
			contPrev <= 1'b0;
			contReq <= 1'b0;
		end else begin
			contSync <= {contSync[0], userCont};
			contPrev <= contSync[1];
			// Scene start drops any old press
			if (restart)
				contReq <= 1'b0;
			else if (contRise)
				contReq <= 1'b1;
		end
	end

	// Restartable pacing timer, frozen while a tick is pending
	always_ff @(posedge clk) begin
		if (rst || restart) begin
			tickCount <= '0;
			tickReq <= 1'b0;
		end else if (!tickReq) begin
			if (tickCount == cntBits'(tickCycles - 1)) begin
				tickCount <= '0;
				tickReq <= 1'b1;
			end else begin
				tickCount <= tickCount + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/framePainter.sv ====
module framePainter #(
	parameter int screenWidth = 160,
	parameter int screenHeight = 120
) (
	input logic clk,
	input logic rst,
	input scenePkg::paintReq_t paintReq,
	input logic paintValid,
	output logic paintReady,
	output scenePkg::pixel_t pixel,
	output logic pixelValid,
	input logic pixelReady,
	output logic frameDone
);

	// Frame in progress
	logic busy;
	// Scene latched at request accept
	scenePkg::scene_e sceneReg;
	// Screen position and running address
	logic [scenePkg::xBits-1:0] xCount;
	logic [scenePkg::yBits-1:0] yCount;
	logic [scenePkg::addrBits-1:0] addrCount;
	logic xEnd;
	logic yEnd;
	logic lastPixel;
	// Record moves this cycle
	logic xfer;
	logic accept;

	assign xEnd = (xCount == scenePkg::xBits'(screenWidth - 1));
	assign yEnd = (yCount == scenePkg::yBits'(screenHeight - 1));
	assign lastPixel = xEnd && yEnd;

	assign paintReady = ~busy;
	assign accept = paintValid && paintReady;
	assign xfer = busy && pixelReady;

	// Busy from accept until the last record moves
	always_ff @(posedge clk) begin
		if (rst)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (xfer && lastPixel)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept)
			sceneReg <= paintReq.scene;
	end

	// Raster counters, x first then y; address just counts up
	always_ff @(posedge clk) begin
		if (rst || accept) begin
			xCount <= '0;
			yCount <= '0;
			addrCount <= '0;
		end else if (xfer && !lastPixel) begin
			addrCount <= addrCount + 1'b1;
			if (xEnd) begin
				xCount <= '0;
				yCount <= yCount + 1'b1;
			end else begin
				xCount <= xCount + 1'b1;
			end
		end
	end

	// Record straight from the counters, steady while stalled
	assign pixel.x = xCount;
	assign pixel.y = yCount;
	assign pixel.addr = addrCount;
	assign pixel.scene = sceneReg;
	assign pixel.last = lastPixel;
	assign pixelValid = busy;

	assign frameDone = xfer && lastPixel;

endmodule

// ==== hdl/sceneController.sv ====
module sceneController #(
	parameter int screenWidth = scenePkg::maxWidth,
	parameter int screenHeight = scenePkg::maxHeight,
	// 4 Hz pacing at 50 MHz
	parameter int tickCycles = 12_500_000
) (
	input logic clk,
	input logic rst,
	input logic userCont,
	input logic pixelReady,
	output scenePkg::pixel_t pixel,
	output logic pixelValid
);

	// Requests into the sequencer
	logic contReq;
	logic tickReq;
	logic restart;
	// Sequencer to painter handshake
	scenePkg::paintReq_t paintReq;
	logic paintValid;
	logic paintReady;
	logic frameDone;

	// Button and pacing timer
	advanceInputs #(
		.tickCycles(tickCycles)
	) inputs (
		.clk(clk),
		.rst(rst),
		.userCont(userCont),
		.restart(restart),
		.contReq(contReq),
		.tickReq(tickReq)
	);

	// Scene order and phases
	sceneSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.contReq(contReq),
		.tickReq(tickReq),
		.frameDone(frameDone),
		.restart(restart),
		.paintReq(paintReq),
		.paintValid(paintValid),
		.paintReady(paintReady)
	);

	// Pixel record stream
	framePainter #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight)
	) painter (
		.clk(clk),
		.rst(rst),
		.paintReq(paintReq),
		.paintValid(paintValid),
		.paintReady(paintReady),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady),
		.frameDone(frameDone)
	);

endmodule

// ==== hdl/scenePkg.sv ====
package scenePkg;

	// Largest screen the counters are sized for
	localparam int maxWidth = 160;
	localparam int maxHeight = 120;

	// Counter widths for the largest screen
	localparam int xBits = $clog2(maxWidth);
	localparam int yBits = $clog2(maxHeight);
	localparam int addrBits = $clog2(maxWidth * maxHeight);

	// Scene index width
	localparam int sceneBits = 3;

	// Scene index, also the colour ROM select
	typedef enum logic [sceneBits-1:0] {
		title1 = 3'd0,
		title2 = 3'd1,
		title3 = 3'd2,
		catDog1 = 3'd3,
		catDog2 = 3'd4
	} scene_e;

	// Request from the sequencer to the painter
	typedef struct packed {
		scene_e scene;
	} paintReq_t;

	// One pixel record for the colour ROM
	typedef struct packed {
		logic [xBits-1:0] x;
		logic [yBits-1:0] y;
		logic [addrBits-1:0] addr;
		scene_e scene;
		// Final pixel of the frame
		logic last;
	} pixel_t;

endpackage

// ==== hdl/sceneSequencer.sv ====
module sceneSequencer (
	input logic clk,
	input logic rst,
	input logic contReq,
	input logic tickReq,
	input logic frameDone,
	output logic restart,
	output scenePkg::paintReq_t paintReq,
	output logic paintValid,
	input logic paintReady
);

	// Phases of every scene, plus one idle cycle out of reset
	typedef enum logic [2:0] {
		phIdle,
		phLoad,
		phRequest,
		phDraw,
		phHold
	} phase_e;

	phase_e phase;
	phase_e phaseNext;
	scenePkg::scene_e scene;
	scenePkg::scene_e sceneNext;
	// Title scenes listen to the continue button
	logic isTitle;
	// Leave the current scene this cycle
	logic advance;
	// Frame finished, either now or earlier
	logic painted;

	assign isTitle = (scene == scenePkg::title1) ||
		(scene == scenePkg::title2) ||
		(scene == scenePkg::title3);

	assign painted = ((phase == phDraw) && frameDone) || (phase == phHold);

	// Continue beats the pacing tick
	always_comb begin
		advance = 1'b0;
		sceneNext = scene;
		if (painted) begin
			if (isTitle && contReq) begin
				advance = 1'b1;
				sceneNext = scenePkg::catDog1;
			end else if (tickReq) begin
				advance = 1'b1;
				case (scene)
					scenePkg::title1: sceneNext = scenePkg::title2;
					scenePkg::title2: sceneNext = scenePkg::title3;
					scenePkg::title3: sceneNext = scenePkg::title1;
					scenePkg::catDog1: sceneNext = scenePkg::catDog2;
					default: sceneNext = scenePkg::catDog1;
				endcase
			end
		end
	end

	// Phase transitions
	always_comb begin
		phaseNext = phase;
		case (phase)
			phIdle: phaseNext = phLoad;
			phLoad: phaseNext = phRequest;
			// Wait for the painter to go idle
			phRequest: if (paintReady) phaseNext = phDraw;
			phDraw: begin
				if (advance)
					phaseNext = phLoad;
				else if (frameDone)
					phaseNext = phHold;
			end
			phHold: if (advance) phaseNext = phLoad;
			default: phaseNext = phIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= phIdle;
			scene <= scenePkg::title1;
		end else begin
			phase <= phaseNext;
			if (advance)
				scene <= sceneNext;
		end
	end

	// Load cycle restarts the timer and clears requests
	assign restart = (phase == phLoad);
	assign paintValid = (phase == phRequest);
	assign paintReq.scene = scene;

endmodule

// ==== vlog.f ====
hdl/scenePkg.sv
hdl/advanceInputs.sv
hdl/sceneSequencer.sv
hdl/framePainter.sv
hdl/sceneController.sv
dv/sceneController_assertions.sv
dv/sceneControllerTb.sv
